/* Makefile */
TOP := tb_axis_frame_merge

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f rtl/*.sv sim/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f --top-module $(TOP)

run: obj_dir/V$(TOP) sim/golden_frames.txt
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* flist.f */
rtl/axis_types_pkg.sv
rtl/frame_status_pkg.sv
rtl/axis_frame_fifo.sv
rtl/axis_frame_arbiter.sv
rtl/axis_frame_merge.sv
sim/clk_gen.sv
sim/tb_axis_frame_merge.sv

/* rtl/axis_frame_arbiter.sv */
module axis_frame_arbiter
  import axis_types_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  axis_beat_t [1:0] in_beat,
  input  logic [1:0]       in_valid,
  output logic [1:0]       in_ready,
  output axis_beat_t       m_beat,
  output logic             m_valid,
  input  logic             m_ready
);

  logic busy_reg;
  logic grant_reg;
  logic last_served_reg;
  logic pick;
  logic sel;
  logic xfer;

  // round robin, the port after the last one served goes first.
  assign pick = in_valid[~last_served_reg] ? ~last_served_reg : last_served_reg;
  assign sel  = busy_reg ? grant_reg : pick;
  assign xfer = m_valid && m_ready;

  assign m_valid = in_valid[sel];

  always_comb begin
    m_beat      = in_beat[sel];
    m_beat.dest = dest_width'(sel);
  end

  always_comb begin
    in_ready      = '0;
    in_ready[sel] = m_ready && (busy_reg || m_valid);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_reg        <= 1'b0;
      grant_reg       <= 1'b0;
      last_served_reg <= 1'b1;
    end else if (xfer && m_beat.last) begin
      busy_reg        <= 1'b0;
      last_served_reg <= sel;
    end else if (!busy_reg && m_valid) begin
      // lock the grant until the end of the frame.
      busy_reg  <= 1'b1;
      grant_reg <= sel;
    end
  end

  a_one_ready: assert property (@(posedge clk) disable iff (rst)
    $onehot0(in_ready));

  a_grant_held: assert property (@(posedge clk) disable iff (rst)
    busy_reg && !(xfer && m_beat.last) |=> busy_reg && $stable(grant_reg));

endmodule

/* rtl/axis_frame_fifo.sv */
module axis_frame_fifo
  import axis_types_pkg::*, frame_status_pkg::*;
#(
  parameter int addr_width     = 6,
  parameter bit drop_bad_frame = 1'b1,
  parameter bit drop_when_full = 1'b1
) (
  input  logic          clk,
  input  logic          rst,
  input  axis_beat_t    s_beat,
  input  logic          s_valid,
  output logic          s_ready,
  output axis_beat_t    m_beat,
  output logic          m_valid,
  input  logic          m_ready,
  output frame_status_t status
);

  localparam logic [addr_width:0] depth = {1'b1, {addr_width{1'b0}}};

  // committed pointer and pointer of the frame being written.
  logic [addr_width:0] wr_ptr_reg;
  logic [addr_width:0] wr_ptr_next;
  logic [addr_width:0] wr_ptr_cur_reg;
  logic [addr_width:0] wr_ptr_cur_next;
  logic [addr_width:0] rd_ptr_reg;
  logic [addr_width:0] rd_ptr_next;
  logic [addr_width-1:0] rd_addr_reg;
  logic [addr_width:0] ptr_used;

  axis_beat_t mem [2**addr_width];
  axis_beat_t mem_rd_data_reg;
  logic mem_rd_valid_reg;
  logic mem_rd_valid_next;
  axis_beat_t m_beat_reg;
  logic m_valid_reg;
  logic m_valid_next;

  logic full_cur;
  logic full_wr;
  logic empty;
  logic frame_bad;
  logic write;
  logic read;
  logic store_output;
  logic drop_frame_reg;
  logic drop_frame_next;
  frame_status_t status_reg;
  frame_status_t status_next;

  // the frame in progress has filled all space up to the read pointer.
  assign full_cur = wr_ptr_cur_reg == {~rd_ptr_reg[addr_width], rd_ptr_reg[addr_width-1:0]};
  // the frame in progress is as long as the whole memory and can never fit.
  assign full_wr  = wr_ptr_cur_reg == {~wr_ptr_reg[addr_width], wr_ptr_reg[addr_width-1:0]};
  assign empty    = wr_ptr_reg == rd_ptr_reg;
  assign ptr_used = wr_ptr_reg - rd_ptr_reg;

  assign frame_bad = drop_bad_frame && s_beat.user[bad_frame_bit];

  assign s_ready = !full_cur || full_wr || drop_when_full;
  assign m_beat  = m_beat_reg;
  assign m_valid = m_valid_reg;
  assign status  = status_reg;

  always_comb begin
    write           = 1'b0;
    drop_frame_next = drop_frame_reg;
    status_next     = '0;
    wr_ptr_next     = wr_ptr_reg;
    wr_ptr_cur_next = wr_ptr_cur_reg;
    if (s_valid && s_ready) begin
      if (full_cur || full_wr || drop_frame_reg) begin
        // out of space, discard the rest of the frame.
        drop_frame_next = 1'b1;
        if (s_beat.last) begin
          drop_frame_next      = 1'b0;
          wr_ptr_cur_next      = wr_ptr_reg;
          status_next.overflow = 1'b1;
        end
      end else begin
        write           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur_reg + 1'b1;
        if (s_beat.last) begin
          if (frame_bad) begin
            wr_ptr_cur_next       = wr_ptr_reg;
            status_next.bad_frame = 1'b1;
          end else begin
            wr_ptr_next            = wr_ptr_cur_reg + 1'b1;
            status_next.good_frame = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_reg     <= '0;
      wr_ptr_cur_reg <= '0;
      drop_frame_reg <= 1'b0;
      status_reg     <= '0;
    end else begin
      wr_ptr_reg     <= wr_ptr_next;
      wr_ptr_cur_reg <= wr_ptr_cur_next;
      drop_frame_reg <= drop_frame_next;
      status_reg     <= status_next;
    end
    if (write) begin
      mem[wr_ptr_cur_reg[addr_width-1:0]] <= s_beat;
    end
  end

  // first read stage, memory to read data register.
  always_comb begin
    read              = 1'b0;
    rd_ptr_next       = rd_ptr_reg;
    mem_rd_valid_next = mem_rd_valid_reg;
    if (store_output || !mem_rd_valid_reg) begin
      if (!empty) begin
        read              = 1'b1;
        mem_rd_valid_next = 1'b1;
        rd_ptr_next       = rd_ptr_reg + 1'b1;
      end else begin
        mem_rd_valid_next = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_reg       <= '0;
      mem_rd_valid_reg <= 1'b0;
    end else begin
      rd_ptr_reg       <= rd_ptr_next;
      mem_rd_valid_reg <= mem_rd_valid_next;
    end
    rd_addr_reg <= rd_ptr_next[addr_width-1:0];
    if (read) begin
      mem_rd_data_reg <= mem[rd_addr_reg];
    end
  end

  // second read stage, output register.
  always_comb begin
    store_output = 1'b0;
    m_valid_next = m_valid_reg;
    if (m_ready || !m_valid_reg) begin
      store_output = 1'b1;
      m_valid_next = mem_rd_valid_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid_reg <= 1'b0;
    end else begin
      m_valid_reg <= m_valid_next;
    end
    if (store_output) begin
      m_beat_reg <= mem_rd_data_reg;
    end
  end

  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    ptr_used <= depth);

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

/* rtl/axis_frame_merge.sv */
module axis_frame_merge
  import axis_types_pkg::*, frame_status_pkg::*;
#(
  parameter int addr_width = 6
) (
  input  logic          clk,
  input  logic          rst,
  input  axis_beat_t    s0_beat,
  input  logic          s0_valid,
  output logic          s0_ready,
  input  axis_beat_t    s1_beat,
  input  logic          s1_valid,
  output logic          s1_ready,
  output axis_beat_t    m_beat,
  output logic          m_valid,
  input  logic          m_ready,
  output frame_status_t s0_status,
  output frame_status_t s1_status
);

  axis_beat_t [1:0] fifo_beat;
  logic [1:0] fifo_valid;
  logic [1:0] fifo_ready;

  axis_frame_fifo #(
    .addr_width     (addr_width),
    .drop_bad_frame (1'b1),
    .drop_when_full (1'b1)
  ) fifo0_i (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s0_beat),
    .s_valid (s0_valid),
    .s_ready (s0_ready),
    .m_beat  (fifo_beat[0]),
    .m_valid (fifo_valid[0]),
    .m_ready (fifo_ready[0]),
    .status  (s0_status)
  );

  axis_frame_fifo #(
    .addr_width     (addr_width),
    .drop_bad_frame (1'b1),
    .drop_when_full (1'b1)
  ) fifo1_i (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s1_beat),
    .s_valid (s1_valid),
    .s_ready (s1_ready),
    .m_beat  (fifo_beat[1]),
    .m_valid (fifo_valid[1]),
    .m_ready (fifo_ready[1]),
    .status  (s1_status)
  );

  axis_frame_arbiter arbiter_i (
    .clk      (clk),
    .rst      (rst),
    .in_beat  (fifo_beat),
    .in_valid (fifo_valid),
    .in_ready (fifo_ready),
    .m_beat   (m_beat),
    .m_valid  (m_valid),
    .m_ready  (m_ready)
  );

endmodule

/* rtl/axis_types_pkg.sv */
package axis_types_pkg;

  // stream geometry.
  localparam int data_width = 32;
  localparam int keep_width = data_width / 8;
  localparam int user_width = 2;

  // one dest bit is enough to name the two input ports.
  localparam int dest_width = 1;

  // one beat of the byte stream, 40 bits.
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [keep_width-1:0] keep;
    logic                  last;
    logic [user_width-1:0] user;
    logic [dest_width-1:0] dest;
  } axis_beat_t;

endpackage

/* rtl/frame_status_pkg.sv */
package frame_status_pkg;

  // user bit that marks a frame as bad on its last beat.
  localparam int bad_frame_bit = 0;

  // one-cycle strobes, raised in the cycle after the last beat of a frame.
  typedef struct packed {
    logic overflow;
    logic bad_frame;
    logic good_frame;
  } frame_status_t;

endpackage

/* sim/clk_gen.sv */
module clk_gen #(
  parameter int half_period  = 5,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever begin
      #half_period clk = ~clk;
    end
  end

  // reset is held for a fixed number of rising edges.
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* sim/golden_frames.txt */
# F port outcome opens a frame (G kept, B marked bad, O overflow)
# data keep user count in hex give a run of beats with rising data and last on the final one
F 0 G
11000000 f 0 4
F 1 G
21000000 f 0 3
F 0 G
12000000 1 2 1
F 1 B
22000000 f 0 4
22000004 f 1 1
F 0 G
13000000 f 0 7
13000007 3 0 1
F 0 B
14000000 f 0 2
14000002 f 1 1
F 1 G
23000000 f 0 a
F 0 O
15000000 f 0 46
F 1 O
24000000 f 2 50
F 0 G
16000000 f 2 c
F 1 G
25000000 3 0 1
F 0 G
17000000 f 0 2
F 1 G
26000000 f 0 6
26000006 7 2 1
F 0 B
18000000 7 1 1
F 1 G
27000000 f 0 14
F 0 G
19000000 f 0 f
1900000f 1 0 1
F 1 B
28000000 f 0 1
28000001 f 3 1
F 1 G
29000000 f 0 5
29000005 e 0 1

/* sim/tb_axis_frame_merge.sv */
module tb_axis_frame_merge
  import axis_types_pkg::*, frame_status_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int fifo_addr_width = 6;
  localparam int fifo_depth      = 2 ** fifo_addr_width;

  logic          clk;
  logic          rst;
  axis_beat_t    s0_beat;
  logic          s0_valid;
  logic          s0_ready;
  axis_beat_t    s1_beat;
  logic          s1_valid;
  logic          s1_ready;
  axis_beat_t    m_beat;
  logic          m_valid;
  logic          m_ready;
  frame_status_t s0_status;
  frame_status_t s1_status;

  // stimulus per port and the kept frames expected at the output.
  axis_beat_t drive0 [$];
  axis_beat_t drive1 [$];
  axis_beat_t exp0 [$];
  axis_beat_t exp1 [$];
  axis_beat_t frame_q [$];

  int exp_good [2];
  int exp_bad [2];
  int exp_over [2];
  int seen_good [2];
  int seen_bad [2];
  int seen_over [2];
  int total_beats;
  int timeout_limit;
  int cycle_count;

  logic loaded;
  logic done0;
  logic done1;
  logic gap0;
  logic gap1;
  logic frame_open;
  logic cur_port;
  byte  cur_outcome;
  logic stall_prev;
  axis_beat_t stall_beat;
  logic in_frame;
  logic [dest_width-1:0] frame_dest;

  clk_gen clk_gen_i (
    .clk (clk),
    .rst (rst)
  );

  axis_frame_merge #(
    .addr_width (fifo_addr_width)
  ) axis_frame_merge_i (
    .clk       (clk),
    .rst       (rst),
    .s0_beat   (s0_beat),
    .s0_valid  (s0_valid),
    .s0_ready  (s0_ready),
    .s1_beat   (s1_beat),
    .s1_valid  (s1_valid),
    .s1_ready  (s1_ready),
    .m_beat    (m_beat),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .s0_status (s0_status),
    .s1_status (s1_status)
  );

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_value_error(input string name, input logic [63:0] expected,
                                    input logic [63:0] actual);
    $display("CHECK FAILED %s expected 0x%0h got 0x%0h", name, expected, actual);
    abort_run();
  endtask

  task automatic report_plain_error(input string msg);
    $display("ERROR: %s", msg);
    abort_run();
  endtask

  // galois form of x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hb400;
    end
    return state >> 1;
  endfunction

  // closes the frame being read and sets last on its final beat.
  task automatic flush_frame();
    axis_beat_t tail;
    if (frame_open) begin
      assert (frame_q.size() > 0)
        else report_plain_error("a frame in the golden file has no beats");
      assert (cur_outcome != "O" || frame_q.size() > fifo_depth)
        else report_plain_error("an overflow frame in the golden file fits the FIFO");
      tail = frame_q.pop_back();
      tail.last = 1'b1;
      frame_q.push_back(tail);
      foreach (frame_q[i]) begin
        if (cur_port) begin
          drive1.push_back(frame_q[i]);
        end else begin
          drive0.push_back(frame_q[i]);
        end
        if (cur_outcome == "G" && cur_port) begin
          exp1.push_back(frame_q[i]);
        end else if (cur_outcome == "G") begin
          exp0.push_back(frame_q[i]);
        end
      end
      if (cur_outcome == "G") begin
        exp_good[cur_port] += 1;
      end else if (cur_outcome == "B") begin
        exp_bad[cur_port] += 1;
      end else begin
        exp_over[cur_port] += 1;
      end
      frame_q.delete();
      frame_open = 1'b0;
    end
  endtask

  task automatic load_golden();
    int fd;
    int n;
    int run_v;
    string line;
    logic [data_width-1:0] data_v;
    logic [keep_width-1:0] keep_v;
    logic [user_width-1:0] user_v;
    axis_beat_t beat;
    fd = $fopen("sim/golden_frames.txt", "r");
    assert (fd != 0)
      else report_plain_error("cannot open sim/golden_frames.txt");
    frame_open  = 1'b0;
    total_beats = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      if (line.getc(0) == "F") begin
        flush_frame();
        assert (line.getc(2) == "0" || line.getc(2) == "1")
          else report_plain_error("bad port number in the golden file");
        cur_port    = line.getc(2) == "1";
        cur_outcome = line.getc(4);
        assert (cur_outcome == "G" || cur_outcome == "B" || cur_outcome == "O")
          else report_plain_error("unknown outcome letter in the golden file");
        frame_open = 1'b1;
      end else begin
        n = $sscanf(line, "%h %h %h %h", data_v, keep_v, user_v, run_v);
        assert (n == 4 && frame_open)
          else report_plain_error("malformed beat line in the golden file");
        for (int i = 0; i < run_v; i++) begin
          beat      = '0;
          beat.data = data_v + 32'(i);
          beat.keep = keep_v;
          beat.user = user_v;
          frame_q.push_back(beat);
          total_beats += 1;
        end
      end
    end
    flush_frame();
    $fclose(fd);
  endtask

  task automatic check_output_beat(input axis_beat_t got);
    axis_beat_t want;
    want = '0;
    if (in_frame) begin
      assert (got.dest == frame_dest)
        else report_value_error("m_beat.dest", 64'(frame_dest), 64'(got.dest));
    end
    if (got.dest == 1'b0) begin
      assert (exp0.size() != 0)
        else report_plain_error("a beat for port 0 arrived with no kept frame pending");
      want = exp0.pop_front();
    end else begin
      assert (exp1.size() != 0)
        else report_plain_error("a beat for port 1 arrived with no kept frame pending");
      want = exp1.pop_front();
    end
    assert (got.data == want.data)
      else report_value_error("m_beat.data", 64'(want.data), 64'(got.data));
    assert (got.keep == want.keep)
      else report_value_error("m_beat.keep", 64'(want.keep), 64'(got.keep));
    assert (got.user == want.user)
      else report_value_error("m_beat.user", 64'(want.user), 64'(got.user));
    assert (got.last == want.last)
      else report_value_error("m_beat.last", 64'(want.last), 64'(got.last));
    in_frame   = !got.last;
    frame_dest = got.dest;
  endtask

  task automatic check_port_counts(input logic port);
    assert (seen_good[port] == exp_good[port])
      else report_value_error($sformatf("s%0d_status.good_frame count", port),
                              64'(exp_good[port]), 64'(seen_good[port]));
    assert (seen_bad[port] == exp_bad[port])
      else report_value_error($sformatf("s%0d_status.bad_frame count", port),
                              64'(exp_bad[port]), 64'(seen_bad[port]));
    assert (seen_over[port] == exp_over[port])
      else report_value_error($sformatf("s%0d_status.overflow count", port),
                              64'(exp_over[port]), 64'(seen_over[port]));
  endtask

  // back-pressure and valid gaps take one lfsr step per bit.
  initial begin : random_source
    logic [15:0] lfsr;
    logic ready_a;
    logic ready_b;
    lfsr    = 16'd89;
    m_ready = 1'b0;
    gap0    = 1'b1;
    gap1    = 1'b1;
    forever begin
      @(posedge clk);
      ready_a = lfsr[0];
      lfsr    = lfsr_step(lfsr);
      ready_b = lfsr[0];
      lfsr    = lfsr_step(lfsr);
      m_ready <= ready_a || ready_b;
      gap0    <= lfsr[0];
      lfsr    = lfsr_step(lfsr);
      gap1    <= lfsr[0];
      lfsr    = lfsr_step(lfsr);
    end
  end

  initial begin : drive_port0
    int idx;
    idx      = 0;
    done0    = 1'b0;
    s0_valid = 1'b0;
    s0_beat  = '0;
    wait (loaded === 1'b1 && rst === 1'b0);
    while (idx < drive0.size()) begin
      @(posedge clk);
      if (s0_valid && s0_ready) begin
        idx += 1;
      end
      if (!s0_valid || s0_ready) begin
        if (idx < drive0.size() && !gap0) begin
          s0_valid <= 1'b1;
          s0_beat  <= drive0[idx];
        end else begin
          s0_valid <= 1'b0;
        end
      end
    end
    done0 = 1'b1;
  end

  initial begin : drive_port1
    int idx;
    idx      = 0;
    done1    = 1'b0;
    s1_valid = 1'b0;
    s1_beat  = '0;
    wait (loaded === 1'b1 && rst === 1'b0);
    while (idx < drive1.size()) begin
      @(posedge clk);
      if (s1_valid && s1_ready) begin
        idx += 1;
      end
      if (!s1_valid || s1_ready) begin
        if (idx < drive1.size() && !gap1) begin
          s1_valid <= 1'b1;
          s1_beat  <= drive1[idx];
        end else begin
          s1_valid <= 1'b0;
        end
      end
    end
    done1 = 1'b1;
  end

  always @(posedge clk) begin : monitor
    if (rst) begin
      stall_prev = 1'b0;
      in_frame   = 1'b0;
      frame_dest = '0;
    end else begin
      if (s0_status.good_frame) seen_good[0] += 1;
      if (s0_status.bad_frame)  seen_bad[0]  += 1;
      if (s0_status.overflow)   seen_over[0] += 1;
      if (s1_status.good_frame) seen_good[1] += 1;
      if (s1_status.bad_frame)  seen_bad[1]  += 1;
      if (s1_status.overflow)   seen_over[1] += 1;
      // frames that do not fit are dropped, so the inputs are never stalled.
      assert (s0_ready)
        else report_value_error("s0_ready", 64'h1, 64'(s0_ready));
      assert (s1_ready)
        else report_value_error("s1_ready", 64'h1, 64'(s1_ready));
      // a stalled beat must be held unchanged.
      if (stall_prev) begin
        assert (m_valid)
          else report_plain_error("m_valid dropped while the output beat was stalled");
        assert (m_beat == stall_beat)
          else report_value_error("m_beat", 64'(stall_beat), 64'(m_beat));
      end
      stall_prev = m_valid && !m_ready;
      stall_beat = m_beat;
      if (m_valid && m_ready) begin
        check_output_beat(m_beat);
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_count += 1;
    if (loaded && cycle_count > timeout_limit) begin
      report_plain_error($sformatf("timeout after %0d cycles with frames still in flight",
                                   cycle_count));
    end
  end

  initial begin : main_sequence
    loaded = 1'b0;
    load_golden();
    timeout_limit = 8 * total_beats + 1000;
    loaded = 1'b1;
    wait (done0 === 1'b1 && done1 === 1'b1);
    // the strobe of the last frame follows its last beat by one cycle.
    repeat (2) @(posedge clk);
    while (exp0.size() != 0 || exp1.size() != 0) begin
      @(posedge clk);
    end
    check_port_counts(1'b0);
    check_port_counts(1'b1);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
